//--- source/vsg_pkg.sv
`default_nettype none

package vsg_pkg;

    // Horizontal raster, in clocks
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 8;
    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_TOTAL  = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;

    localparam int H_ACTIVE_START = H_SYNC + H_BACK;
    localparam int H_ACTIVE_END   = H_ACTIVE_START + H_ACTIVE;

    // Vertical raster, in lines
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 3;
    localparam int V_ACTIVE = 24;
    localparam int V_FRONT  = 2;
    localparam int V_TOTAL  = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;

    localparam int V_ACTIVE_START = V_SYNC + V_BACK;
    localparam int V_ACTIVE_END   = V_ACTIVE_START + V_ACTIVE;

    localparam int COUNT_W = 11;

    // Colour bar layout, rows relative to active start
    localparam int BAND_WHITE_Y = V_ACTIVE * 7 / 12;
    localparam int BAND_RAMP_Y  = V_ACTIVE * 8 / 12;

    // Bar edges relative to active start
    localparam int BAR_EDGE [0:5] = '{
        1 * H_ACTIVE / 7,
        2 * H_ACTIVE / 7,
        3 * H_ACTIVE / 7,
        4 * H_ACTIVE / 7,
        5 * H_ACTIVE / 7,
        6 * H_ACTIVE / 7
    };

    localparam logic [7:0] LEVEL_75  = 8'hBF;
    localparam logic [7:0] LEVEL_100 = 8'hFF;

    // 8.8 fixed point step of the grey ramp
    localparam logic [15:0] RAMP_STEP = 16'(255 * 256 / (H_ACTIVE - 1));

    typedef struct packed {
        logic [COUNT_W-1:0] hcount;
        logic [COUNT_W-1:0] vcount;
    } raster_pos_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic hblank;
        logic vblank;
        logic de;
        logic framestart;
        logic linestart;
        logic pixrequest;
    } sync_flags_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef enum logic [1:0] {
        BAND_BARS,
        BAND_WHITE,
        BAND_RAMP
    } cb_band_e;

    // White, yellow, cyan, green, magenta, red, blue
    localparam pixel_t BAR_COLOR [0:6] = '{
        '{LEVEL_75, LEVEL_75, LEVEL_75},
        '{LEVEL_75, LEVEL_75, 8'h00},
        '{8'h00, LEVEL_75, LEVEL_75},
        '{8'h00, LEVEL_75, 8'h00},
        '{LEVEL_75, 8'h00, LEVEL_75},
        '{LEVEL_75, 8'h00, 8'h00},
        '{8'h00, 8'h00, LEVEL_75}
    };

endpackage

`default_nettype wire

//--- source/raster_counter.sv
`default_nettype none

module raster_counter (
    input  logic                 clk,
    input  logic                 rst,
    output vsg_pkg::raster_pos_t pos
);

    logic h_wrap;
    logic v_wrap;

    assign h_wrap = (pos.hcount == vsg_pkg::H_TOTAL - 1);
    assign v_wrap = (pos.vcount == vsg_pkg::V_TOTAL - 1);

    // Pixel position within the line
    always_ff @(posedge clk) begin
        if (rst) begin
            pos.hcount <= '0;
        end else if (h_wrap) begin
            pos.hcount <= '0;
        end else begin
            pos.hcount <= pos.hcount + 1'b1;
        end
    end

    // Line number, steps once per line
    always_ff @(posedge clk) begin
        if (rst) begin
            pos.vcount <= '0;
        end else if (h_wrap) begin
            if (v_wrap) begin
                pos.vcount <= '0;
            end else begin
                pos.vcount <= pos.vcount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/sync_timing.sv
`default_nettype none

module sync_timing (
    input  logic                 clk,
    input  logic                 rst,
    input  vsg_pkg::raster_pos_t pos,
    input  logic                 scan_ena,
    output vsg_pkg::sync_flags_t flags
);

    logic h_active;
    logic v_active;
    logic frame_top;
    logic scan_sync;
    logic scan_frame;
    vsg_pkg::sync_flags_t flags_next;

    assign h_active = (pos.hcount >= vsg_pkg::H_ACTIVE_START) &&
                      (pos.hcount < vsg_pkg::H_ACTIVE_END);
    assign v_active = (pos.vcount >= vsg_pkg::V_ACTIVE_START) &&
                      (pos.vcount < vsg_pkg::V_ACTIVE_END);
    assign frame_top = (pos.hcount == '0) && (pos.vcount == '0);

    // scan_ena is sampled once per frame at the top-left corner
    always_ff @(posedge clk) begin
        if (rst) begin
            scan_sync  <= 1'b0;
            scan_frame <= 1'b0;
        end else begin
            scan_sync <= scan_ena;
            if (frame_top) begin
                scan_frame <= scan_sync;
            end
        end
    end

    always_comb begin
        flags_next.hsync      = (pos.hcount < vsg_pkg::H_SYNC);
        flags_next.vsync      = (pos.vcount < vsg_pkg::V_SYNC);
        flags_next.hblank     = !h_active;
        flags_next.vblank     = !v_active;
        flags_next.de         = h_active && v_active;
        flags_next.framestart = frame_top;
        // Line and pixel requests only in scanned frames
        flags_next.linestart  = (pos.hcount == '0) && v_active && scan_frame;
        flags_next.pixrequest = h_active && v_active && scan_frame;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags.hsync      <= 1'b0;
            flags.vsync      <= 1'b0;
            flags.hblank     <= 1'b1;
            flags.vblank     <= 1'b1;
            flags.de         <= 1'b0;
            flags.framestart <= 1'b0;
            flags.linestart  <= 1'b0;
            flags.pixrequest <= 1'b0;
        end else begin
            flags <= flags_next;
        end
    end

endmodule

`default_nettype wire

//--- source/colorbar_gen.sv
`default_nettype none

module colorbar_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  vsg_pkg::raster_pos_t pos,
    output vsg_pkg::pixel_t      pixel
);

    vsg_pkg::cb_band_e band;
    logic [2:0]        bar_idx;
    logic [15:0]       ramp_acc;
    logic              line_end;
    logic              pre_active;
    logic              h_active;
    logic              edge_hit;
    logic [7:0]        ramp_level;
    logic [7:0]        white_level;

    assign line_end   = (pos.hcount == vsg_pkg::H_TOTAL - 1);
    assign pre_active = (pos.hcount == vsg_pkg::H_ACTIVE_START - 1);
    assign h_active   = (pos.hcount >= vsg_pkg::H_ACTIVE_START) &&
                        (pos.hcount < vsg_pkg::H_ACTIVE_END);

    // Next position lands on a bar edge
    always_comb begin
        edge_hit = 1'b0;
        for (int k = 0; k < 6; k++) begin
            if (pos.hcount == vsg_pkg::H_ACTIVE_START + vsg_pkg::BAR_EDGE[k] - 1) begin
                edge_hit = 1'b1;
            end
        end
    end

    // Band changes at line ends, so it tracks the vcount of pos
    always_ff @(posedge clk) begin
        if (rst) begin
            band <= vsg_pkg::BAND_BARS;
        end else if (line_end) begin
            case (band)
                vsg_pkg::BAND_BARS: begin
                    if (pos.vcount == vsg_pkg::V_ACTIVE_START + vsg_pkg::BAND_WHITE_Y - 1) begin
                        band <= vsg_pkg::BAND_WHITE;
                    end
                end
                vsg_pkg::BAND_WHITE: begin
                    if (pos.vcount == vsg_pkg::V_ACTIVE_START + vsg_pkg::BAND_RAMP_Y - 1) begin
                        band <= vsg_pkg::BAND_RAMP;
                    end
                end
                vsg_pkg::BAND_RAMP: begin
                    if (pos.vcount == vsg_pkg::V_TOTAL - 1) begin
                        band <= vsg_pkg::BAND_BARS;
                    end
                end
                default: band <= vsg_pkg::BAND_BARS;
            endcase
        end
    end

    // Bar index for the current pos
    always_ff @(posedge clk) begin
        if (rst) begin
            bar_idx <= '0;
        end else if (pre_active) begin
            bar_idx <= '0;
        end else if (edge_hit) begin
            bar_idx <= bar_idx + 1'b1;
        end
    end

    // Ramp level in 8.8 fixed point, x * RAMP_STEP
    always_ff @(posedge clk) begin
        if (pre_active) begin
            ramp_acc <= '0;
        end else if (h_active) begin
            ramp_acc <= ramp_acc + vsg_pkg::RAMP_STEP;
        end
    end

    assign ramp_level  = ramp_acc[15:8];
    assign white_level = (bar_idx == '0) ? vsg_pkg::LEVEL_100 : vsg_pkg::LEVEL_75;

    // Blanking is left to the output stage
    always_ff @(posedge clk) begin
        case (band)
            vsg_pkg::BAND_BARS:  pixel <= vsg_pkg::BAR_COLOR[bar_idx];
            vsg_pkg::BAND_WHITE: pixel <= '{white_level, white_level, white_level};
            vsg_pkg::BAND_RAMP:  pixel <= '{ramp_level, ramp_level, ramp_level};
            default:             pixel <= '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/video_out_stage.sv
`default_nettype none

module video_out_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  vsg_pkg::raster_pos_t         pos,
    input  vsg_pkg::sync_flags_t         flags,
    input  vsg_pkg::pixel_t              pixel,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         hblank,
    output logic                         vblank,
    output logic                         de,
    output logic                         framestart,
    output logic                         linestart,
    output logic                         pixrequest,
    output logic [vsg_pkg::COUNT_W-1:0]  hcount,
    output logic [vsg_pkg::COUNT_W-1:0]  vcount,
    output logic [7:0]                   r,
    output logic [7:0]                   g,
    output logic [7:0]                   b
);

    vsg_pkg::raster_pos_t pos_d;
    vsg_pkg::pixel_t      pixel_vis;

    // Match the one cycle of the flag and pixel registers
    always_ff @(posedge clk) begin
        if (rst) begin
            pos_d <= '0;
        end else begin
            pos_d <= pos;
        end
    end

    assign pixel_vis = flags.de ? pixel : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            hsync      <= 1'b0;
            vsync      <= 1'b0;
            hblank     <= 1'b1;
            vblank     <= 1'b1;
            de         <= 1'b0;
            framestart <= 1'b0;
            linestart  <= 1'b0;
            pixrequest <= 1'b0;
            hcount     <= '0;
            vcount     <= '0;
            r          <= '0;
            g          <= '0;
            b          <= '0;
        end else begin
            hsync      <= flags.hsync;
            vsync      <= flags.vsync;
            hblank     <= flags.hblank;
            vblank     <= flags.vblank;
            de         <= flags.de;
            framestart <= flags.framestart;
            linestart  <= flags.linestart;
            pixrequest <= flags.pixrequest;
            hcount     <= pos_d.hcount;
            vcount     <= pos_d.vcount;
            r          <= pixel_vis.r;
            g          <= pixel_vis.g;
            b          <= pixel_vis.b;
        end
    end

endmodule

`default_nettype wire

//--- source/video_syncgen_top.sv
`default_nettype none

module video_syncgen_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         scan_ena,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         hblank,
    output logic                         vblank,
    output logic                         de,
    output logic                         framestart,
    output logic                         linestart,
    output logic                         pixrequest,
    output logic [vsg_pkg::COUNT_W-1:0]  hcount,
    output logic [vsg_pkg::COUNT_W-1:0]  vcount,
    output logic [7:0]                   r,
    output logic [7:0]                   g,
    output logic [7:0]                   b
);

    vsg_pkg::raster_pos_t pos;
    vsg_pkg::sync_flags_t flags;
    vsg_pkg::pixel_t      pixel;

    // Shared time base for both halves
    raster_counter u_raster_counter (
        .clk (clk),
        .rst (rst),
        .pos (pos)
    );

    sync_timing u_sync_timing (
        .clk      (clk),
        .rst      (rst),
        .pos      (pos),
        .scan_ena (scan_ena),
        .flags    (flags)
    );

    colorbar_gen u_colorbar_gen (
        .clk   (clk),
        .rst   (rst),
        .pos   (pos),
        .pixel (pixel)
    );

    video_out_stage u_video_out_stage (
        .clk        (clk),
        .rst        (rst),
        .pos        (pos),
        .flags      (flags),
        .pixel      (pixel),
        .hsync      (hsync),
        .vsync      (vsync),
        .hblank     (hblank),
        .vblank     (vblank),
        .de         (de),
        .framestart (framestart),
        .linestart  (linestart),
        .pixrequest (pixrequest),
        .hcount     (hcount),
        .vcount     (vcount),
        .r          (r),
        .g          (g),
        .b          (b)
    );

endmodule

`default_nettype wire

//--- tb/video_syncgen_tb.sv
`default_nettype none

module video_syncgen_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [3:0]      kind;
        logic [7:0]      h;
        logic [7:0]      v;
        vsg_pkg::pixel_t pixel;
    } record_t;

    localparam int MAX_RECORDS = 64;
    localparam int RAMP_STEP = 255 * 256 / (vsg_pkg::H_ACTIVE - 1);

    logic clk;
    logic rst;
    logic scan_ena;
    logic hsync, vsync, hblank, vblank, de, framestart, linestart, pixrequest;
    logic [vsg_pkg::COUNT_W-1:0] hcount;
    logic [vsg_pkg::COUNT_W-1:0] vcount;
    logic [7:0] r, g, b;

    logic [43:0] mem [0:MAX_RECORDS-1];
    record_t     frames [$];
    record_t     points [$];
    int          point_hits [$];
    logic        loaded = 1'b0;
    int          timeout_limit = 0;
    int          cycle_count = 0;
    int          mismatches = 0;
    int          failures = 0;
    logic [3:0]  scan_hist;
    logic        frame_scan = 1'b0;
    int          reset_cycles = 0;
    int          exp_h = 0;
    int          exp_v = 0;

    video_syncgen_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // Classic order white, yellow, cyan, green, magenta, red, blue
    function automatic vsg_pkg::pixel_t bar_color(input int idx);
        vsg_pkg::pixel_t p;
        p.r = ((idx % 4) < 2) ? 8'hBF : 8'h00;
        p.g = (idx < 4) ? 8'hBF : 8'h00;
        p.b = ((idx % 2) == 0) ? 8'hBF : 8'h00;
        return p;
    endfunction

    function automatic vsg_pkg::pixel_t expected_pixel(input int h, input int v);
        int         x;
        int         y;
        int         idx;
        logic [7:0] level;
        x = h - vsg_pkg::H_ACTIVE_START;
        y = v - vsg_pkg::V_ACTIVE_START;
        if (x < 0 || x >= vsg_pkg::H_ACTIVE || y < 0 || y >= vsg_pkg::V_ACTIVE) begin
            return '0;
        end
        if (y < vsg_pkg::V_ACTIVE * 7 / 12) begin
            idx = 0;
            for (int k = 1; k <= 6; k++) begin
                if (k * vsg_pkg::H_ACTIVE / 7 <= x) begin
                    idx++;
                end
            end
            return bar_color(idx);
        end else if (y < vsg_pkg::V_ACTIVE * 8 / 12) begin
            level = (x < vsg_pkg::H_ACTIVE / 7) ? 8'hFF : 8'hBF;
        end else begin
            level = 8'((x * RAMP_STEP) >> 8);
        end
        return '{level, level, level};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatches++;
            $display("MISMATCH %s at h=%0d v=%0d: expected %h, actual %h",
                     name, exp_h, exp_v, expected, actual);
        end
    endtask

    task automatic check_reset_outputs();
        check_value("hcount", 0, hcount);
        check_value("vcount", 0, vcount);
        check_value("hsync", 0, hsync);
        check_value("vsync", 0, vsync);
        check_value("hblank", 1, hblank);
        check_value("vblank", 1, vblank);
        check_value("de", 0, de);
        check_value("framestart", 0, framestart);
        check_value("linestart", 0, linestart);
        check_value("pixrequest", 0, pixrequest);
        check_value("rgb", 0, {r, g, b});
    endtask

    task automatic check_position();
        vsg_pkg::sync_flags_t f;
        vsg_pkg::pixel_t      p;
        logic                 h_act;
        logic                 v_act;
        h_act = exp_h >= vsg_pkg::H_ACTIVE_START && exp_h < vsg_pkg::H_ACTIVE_END;
        v_act = exp_v >= vsg_pkg::V_ACTIVE_START && exp_v < vsg_pkg::V_ACTIVE_END;
        // Counter hit (0,0) two cycles ago, scan_ena was taken one cycle before that
        if (exp_h == 0 && exp_v == 0) begin
            frame_scan = scan_hist[3];
        end
        f.hsync      = exp_h < vsg_pkg::H_SYNC;
        f.vsync      = exp_v < vsg_pkg::V_SYNC;
        f.hblank     = !h_act;
        f.vblank     = !v_act;
        f.de         = h_act && v_act;
        f.framestart = exp_h == 0 && exp_v == 0;
        f.linestart  = exp_h == 0 && v_act && frame_scan;
        f.pixrequest = f.de && frame_scan;
        p = expected_pixel(exp_h, exp_v);
        check_value("hcount", exp_h, hcount);
        check_value("vcount", exp_v, vcount);
        check_value("hsync", f.hsync, hsync);
        check_value("vsync", f.vsync, vsync);
        check_value("hblank", f.hblank, hblank);
        check_value("vblank", f.vblank, vblank);
        check_value("de", f.de, de);
        check_value("framestart", f.framestart, framestart);
        check_value("linestart", f.linestart, linestart);
        check_value("pixrequest", f.pixrequest, pixrequest);
        check_value("rgb", p, {r, g, b});
        foreach (points[i]) begin
            if (points[i].h == exp_h && points[i].v == exp_v) begin
                check_value("checkpoint_vs_model", points[i].pixel, p);
                check_value("checkpoint_rgb", points[i].pixel, {r, g, b});
                point_hits[i]++;
            end
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            scan_hist = '0;
            reset_cycles = 0;
        end else begin
            scan_hist = {scan_hist[2:0], scan_ena};
            if (reset_cycles < 2) begin
                // Pipeline still holds reset values
                check_reset_outputs();
                reset_cycles++;
                exp_h = 0;
                exp_v = 0;
            end else begin
                check_position();
                if (exp_h == vsg_pkg::H_TOTAL - 1) begin
                    exp_h = 0;
                    exp_v = (exp_v == vsg_pkg::V_TOTAL - 1) ? 0 : exp_v + 1;
                end else begin
                    exp_h++;
                end
            end
        end
    end

    task automatic load_testdata();
        record_t rec;
        foreach (mem[i]) begin
            mem[i] = '0;
        end
        $readmemh("tb/video_testdata.txt", mem);
        foreach (mem[i]) begin
            rec = mem[i];
            if (rec.kind == 4'h1) begin
                frames.push_back(rec);
            end else if (rec.kind == 4'h2) begin
                points.push_back(rec);
                point_hits.push_back(0);
            end
        end
        timeout_limit = 16 + (frames.size() + 1) * vsg_pkg::H_TOTAL * vsg_pkg::V_TOTAL;
        loaded = 1'b1;
    endtask

    task automatic wait_frame_start();
        do @(negedge clk); while (framestart !== 1'b1);
    endtask

    task automatic wait_line(input int v);
        do @(negedge clk); while (!(hcount == 0 && vcount == v));
    endtask

    task automatic report_counts();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    endtask

    initial begin
        rst = 1'b1;
        scan_ena = 1'b0;
        load_testdata();
        assert (frames.size() > 0) else begin
            failures++;
            $display("No frame records found in the test data file");
        end
        if (frames.size() > 0) begin
            scan_ena = frames[0].pixel[0];
        end
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        for (int k = 0; k < frames.size(); k++) begin
            wait_frame_start();
            // Change mid-frame, takes effect at the next frame
            wait_line(vsg_pkg::V_ACTIVE_START + 10);
            if (k + 1 < frames.size()) begin
                @(posedge clk);
                #1 scan_ena = frames[k + 1].pixel[0];
            end
        end
        wait_frame_start();
        @(posedge clk);
        foreach (points[i]) begin
            assert (point_hits[i] > 0) else begin
                failures++;
                $display("Checkpoint at h=%0d v=%0d was never reached", points[i].h, points[i].v);
            end
        end
        report_counts();
        if (mismatches + failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (loaded === 1'b1);
        wait (cycle_count >= timeout_limit);
        failures++;
        $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
        report_counts();
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
source/vsg_pkg.sv
source/raster_counter.sv
source/sync_timing.sv
source/colorbar_gen.sv
source/video_out_stage.sv
source/video_syncgen_top.sv
tb/video_syncgen_tb.sv

//--- Bender.yml
package:
  name: video_syncgen

sources:
  - source/vsg_pkg.sv
  - source/raster_counter.sv
  - source/sync_timing.sv
  - source/colorbar_gen.sv
  - source/video_out_stage.sv
  - source/video_syncgen_top.sv
  - target: test
    files:
      - tb/video_syncgen_tb.sv

//--- tb/video_testdata.txt
// kind_h_v_rrggbb in hex; kind 1 = frame, scan_ena in the last digit
// kind 2 = checkpoint, expected pixel at output position h, v
1_00_00_000000
1_00_00_000001
1_00_00_000000
1_00_00_000001
// Blanking
2_0F_05_000000
2_50_0A_000000
2_28_04_000000
2_28_1D_000000
// Bars
2_10_05_BFBFBF
2_18_05_BFBFBF
2_19_06_BFBF00
2_22_0A_00BFBF
2_2B_0C_00BF00
2_34_0F_BF00BF
2_3D_11_BF0000
2_46_12_0000BF
2_4F_12_0000BF
// White band
2_10_13_FFFFFF
2_18_14_FFFFFF
2_19_13_BFBFBF
2_4F_14_BFBFBF
// Grey ramp
2_10_15_000000
2_11_15_040404
2_1A_18_282828
2_30_1A_818181
2_4F_1C_FEFEFE
